/* include/rtc_disp_defs.svh */
`ifndef RTC_DISP_DEFS_SVH
`define RTC_DISP_DEFS_SVH

// APB register offsets
`define RTC_OFF_CTRL     8'h00
`define RTC_OFF_CMD      8'h04
`define RTC_OFF_TSET     8'h08
`define RTC_OFF_TNOW     8'h0C
`define RTC_OFF_PRESC    8'h10

// Font ROM layout
// Digit glyphs start here
`define GLYPH_BASE       11'd1024
// Words per glyph
`define GLYPH_STRIDE     11'd36
// Glyph code of the colon, right after digit 9
`define GLYPH_COLON_CODE 4'd10

// Prescaler
`define PRESC_WIDTH      16
// Divide by 50000 out of reset
`define PRESC_DEFAULT    16'd49999

`endif

/* hw/rtc_types_pkg.sv */
package rtc_types_pkg;

    // Command opcodes written to the CMD register
    typedef enum logic [2:0] {
        // No operation
        OP_NOP  = 3'd0,
        // Copy time-set register into the counter
        OP_LOAD = 3'd1,
        // Advance one second
        OP_STEP = 3'd2,
        // Start free running
        OP_RUN  = 3'd3,
        // Stop free running
        OP_STOP = 3'd4
    } rtc_op_e;

    // Register index after address decode
    typedef enum logic [2:0] {
        REG_CTRL  = 3'd0,
        REG_CMD   = 3'd1,
        REG_TSET  = 3'd2,
        REG_TNOW  = 3'd3,
        REG_PRESC = 3'd4,
        // Anything not in the map
        REG_BAD   = 3'd5
    } rtc_reg_e;

    // Packed BCD time, hours in the top nibbles
    typedef struct packed {
        logic [3:0] hour_10;
        logic [3:0] hour_1;
        logic [3:0] minute_10;
        logic [3:0] minute_1;
        logic [3:0] second_10;
        logic [3:0] second_1;
    } bcd_time_t;

endpackage

/* hw/disp_types_pkg.sv */
package disp_types_pkg;

    // Character position on the display line
    // 0..1 hours
    // 2 colon
    // 3..4 minutes
    // 5 colon
    // 6..7 seconds
    typedef logic [2:0] slot_t;

    // Font ROM address of one glyph
    typedef logic [10:0] glyph_addr_t;

    // Character scanner states
    typedef enum logic {
        // Out of reset, nothing presented yet
        SCAN_IDLE = 1'b0,
        // Streaming slots to the display engine
        SCAN_SEND = 1'b1
    } scan_state_e;

endpackage

/* hw/rtc_apb_regs.sv */
`timescale 1ns/100ps

`include "rtc_disp_defs.svh"

module rtc_apb_regs (
    input  logic                      clk,
    input  logic                      reset,
    // APB slave
    input  logic [7:0]                paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Counter side
    input  rtc_types_pkg::bcd_time_t  time_now,
    output logic                      run_en,
    output logic [`PRESC_WIDTH-1:0]   presc_value,
    output rtc_types_pkg::bcd_time_t  tset,
    output logic                      cmd_load,
    output logic                      cmd_step
);

    rtc_types_pkg::rtc_reg_e reg_sel;
    rtc_types_pkg::rtc_op_e  cmd_op;
    logic                    access;
    logic                    wr_en;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (paddr)
            `RTC_OFF_CTRL:  reg_sel = rtc_types_pkg::REG_CTRL;
            `RTC_OFF_CMD:   reg_sel = rtc_types_pkg::REG_CMD;
            `RTC_OFF_TSET:  reg_sel = rtc_types_pkg::REG_TSET;
            `RTC_OFF_TNOW:  reg_sel = rtc_types_pkg::REG_TNOW;
            `RTC_OFF_PRESC: reg_sel = rtc_types_pkg::REG_PRESC;
            default:        reg_sel = rtc_types_pkg::REG_BAD;
        endcase
    end

    // Access phase only, no wait states
    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign pready  = 1'b1;
    assign pslverr = access && (reg_sel == rtc_types_pkg::REG_BAD);

    // Opcode sits in the low bits of the CMD write
    assign cmd_op = rtc_types_pkg::rtc_op_e'(pwdata[2:0]);

    ////////////////////////////////////////////////////////////////////////////
    // Register writes and command strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_en      <= 1'b0;
            presc_value <= `PRESC_DEFAULT;
            tset        <= '0;
            cmd_load    <= 1'b0;
            cmd_step    <= 1'b0;
        end
        else
        begin
            // Strobes last one cycle
            cmd_load <= 1'b0;
            cmd_step <= 1'b0;
            if (wr_en)
            begin
                case (reg_sel)
                    rtc_types_pkg::REG_CTRL:  run_en <= pwdata[0];
                    rtc_types_pkg::REG_TSET:  tset <= rtc_types_pkg::bcd_time_t'(pwdata[23:0]);
                    rtc_types_pkg::REG_PRESC: presc_value <= pwdata[`PRESC_WIDTH-1:0];
                    rtc_types_pkg::REG_CMD:
                    begin
                        case (cmd_op)
                            rtc_types_pkg::OP_LOAD: cmd_load <= 1'b1;
                            rtc_types_pkg::OP_STEP: cmd_step <= 1'b1;
                            rtc_types_pkg::OP_RUN:  run_en <= 1'b1;
                            rtc_types_pkg::OP_STOP: run_en <= 1'b0;
                            // NOP and unknown codes do nothing
                            default: ;
                        endcase
                    end
                    // TNOW is read only, bad offsets write nothing
                    default: ;
                endcase
            end
        end
    end

    // Read data, zero for CMD and for unmapped offsets
    always_comb
    begin
        case (reg_sel)
            rtc_types_pkg::REG_CTRL:  prdata = {31'd0, run_en};
            rtc_types_pkg::REG_TSET:  prdata = {8'd0, tset};
            rtc_types_pkg::REG_TNOW:  prdata = {8'd0, time_now};
            rtc_types_pkg::REG_PRESC: prdata = {{(32-`PRESC_WIDTH){1'b0}}, presc_value};
            default:                  prdata = 32'd0;
        endcase
    end

endmodule

/* hw/rtc_time_counter.sv */
`timescale 1ns/100ps

`include "rtc_disp_defs.svh"

module rtc_time_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run_en,
    input  logic [`PRESC_WIDTH-1:0]   presc_value,
    input  rtc_types_pkg::bcd_time_t  tset,
    input  logic                      cmd_load,
    input  logic                      cmd_step,
    output rtc_types_pkg::bcd_time_t  time_now
);

    logic [`PRESC_WIDTH-1:0]  presc_cnt;
    logic                     sec_tick;
    rtc_types_pkg::bcd_time_t time_inc;
    // Carry out of each digit
    logic                     carry_s1;
    logic                     carry_s10;
    logic                     carry_m1;
    logic                     carry_m10;
    logic                     carry_h1;
    logic                     hour_wrap;

    ////////////////////////////////////////////////////////////////////////////
    // Prescaler
    ////////////////////////////////////////////////////////////////////////////

    // Held at the reload value while stopped
    // so the first tick lands presc_value+1 cycles after run_en rises
    always_ff @(posedge clk)
    begin
        if (reset)
            presc_cnt <= '0;
        else if (!run_en || presc_cnt == '0)
            presc_cnt <= presc_value;
        else
            presc_cnt <= presc_cnt - 1'b1;
    end

    assign sec_tick = run_en && (presc_cnt == '0);

    ////////////////////////////////////////////////////////////////////////////
    // BCD increment
    ////////////////////////////////////////////////////////////////////////////

    assign carry_s1  = (time_now.second_1 == 4'd9);
    assign carry_s10 = carry_s1 && (time_now.second_10 == 4'd5);
    assign carry_m1  = carry_s10 && (time_now.minute_1 == 4'd9);
    assign carry_m10 = carry_m1 && (time_now.minute_10 == 4'd5);
    assign carry_h1  = carry_m10 && (time_now.hour_1 == 4'd9);
    // 23:59:59 rolls to midnight
    assign hour_wrap = carry_m10 && (time_now.hour_10 == 4'd2) && (time_now.hour_1 == 4'd3);

    always_comb
    begin
        time_inc = time_now;
        time_inc.second_1 = carry_s1 ? 4'd0 : time_now.second_1 + 4'd1;
        if (carry_s1)
            time_inc.second_10 = carry_s10 ? 4'd0 : time_now.second_10 + 4'd1;
        if (carry_s10)
            time_inc.minute_1 = carry_m1 ? 4'd0 : time_now.minute_1 + 4'd1;
        if (carry_m1)
            time_inc.minute_10 = carry_m10 ? 4'd0 : time_now.minute_10 + 4'd1;
        if (carry_m10)
            time_inc.hour_1 = (carry_h1 || hour_wrap) ? 4'd0 : time_now.hour_1 + 4'd1;
        // Tens of hours move on 09->10, 19->20 and the wrap
        if (hour_wrap)
            time_inc.hour_10 = 4'd0;
        else if (carry_h1)
            time_inc.hour_10 = time_now.hour_10 + 4'd1;
    end

    // Load beats step, step beats tick
    always_ff @(posedge clk)
    begin
        if (reset)
            time_now <= '0;
        else if (cmd_load)
            time_now <= tset;
        else if (cmd_step || sec_tick)
            time_now <= time_inc;
    end

endmodule

/* hw/rtc_glyph_mux.sv */
`timescale 1ns/100ps

`include "rtc_disp_defs.svh"

module rtc_glyph_mux (
    input  disp_types_pkg::slot_t       slot_sel,
    input  rtc_types_pkg::bcd_time_t    time_now,
    output disp_types_pkg::glyph_addr_t glyph_addr
);

    // Glyph code of the selected slot, 0..9 digit or 10 colon
    logic [3:0] glyph_code;

    ////////////////////////////////////////////////////////////////////////////
    // Slot to glyph code
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (slot_sel)
            3'd0:    glyph_code = time_now.hour_10;
            3'd1:    glyph_code = time_now.hour_1;
            // hh:mm separator
            3'd2:    glyph_code = `GLYPH_COLON_CODE;
            3'd3:    glyph_code = time_now.minute_10;
            3'd4:    glyph_code = time_now.minute_1;
            // mm:ss separator
            3'd5:    glyph_code = `GLYPH_COLON_CODE;
            3'd6:    glyph_code = time_now.second_10;
            default: glyph_code = time_now.second_1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Glyph code to font ROM address
    ////////////////////////////////////////////////////////////////////////////

    // Glyphs packed back to back from the base
    // Codes past the colon fall back to the zero glyph
    always_comb
    begin
        if (glyph_code > `GLYPH_COLON_CODE)
            glyph_addr = `GLYPH_BASE;
        else
            glyph_addr = `GLYPH_BASE
                       + disp_types_pkg::glyph_addr_t'(glyph_code) * `GLYPH_STRIDE;
    end

endmodule

/* hw/rtc_char_scanner.sv */
`timescale 1ns/100ps

module rtc_char_scanner (
    input  logic                        clk,
    input  logic                        reset,
    // Mux side
    input  disp_types_pkg::glyph_addr_t glyph_addr_in,
    output disp_types_pkg::slot_t       slot_sel,
    // Display engine side
    output logic                        glyph_valid,
    input  logic                        glyph_ready,
    output disp_types_pkg::glyph_addr_t glyph_addr,
    output disp_types_pkg::slot_t       glyph_slot
);

    disp_types_pkg::scan_state_e state;
    // Next slot to load
    disp_types_pkg::slot_t       slot_cnt;
    logic                        accept;
    logic                        load_item;

    assign glyph_valid = (state == disp_types_pkg::SCAN_SEND);
    assign accept      = glyph_valid && glyph_ready;
    // First load straight out of idle, then one per accepted item
    assign load_item   = (state == disp_types_pkg::SCAN_IDLE) || accept;

    // Mux looks up the slot about to be loaded
    assign slot_sel = slot_cnt;

    // State and slot counter
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= disp_types_pkg::SCAN_IDLE;
            slot_cnt <= '0;
        end
        else if (load_item)
        begin
            state <= disp_types_pkg::SCAN_SEND;
            // Wraps 7 to 0 for the next frame
            slot_cnt <= slot_cnt + 3'd1;
        end
    end

    // Presented item, held while the engine stalls
    always_ff @(posedge clk)
    begin
        if (load_item)
        begin
            glyph_addr <= glyph_addr_in;
            glyph_slot <= slot_cnt;
        end
    end

endmodule

/* hw/rtc_display_top.sv */
`timescale 1ns/100ps

`include "rtc_disp_defs.svh"

module rtc_display_top (
    input  logic                        clk,
    input  logic                        reset,
    // APB slave
    input  logic [7:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    // Glyph stream to the display engine
    output logic                        glyph_valid,
    input  logic                        glyph_ready,
    output disp_types_pkg::glyph_addr_t glyph_addr,
    output disp_types_pkg::slot_t       glyph_slot
);

    // Register block to counter
    logic                        run_en;
    logic [`PRESC_WIDTH-1:0]     presc_value;
    rtc_types_pkg::bcd_time_t    tset;
    logic                        cmd_load;
    logic                        cmd_step;
    // Current time, shared by TNOW and the mux
    rtc_types_pkg::bcd_time_t    time_now;
    // Scanner to mux and back
    disp_types_pkg::slot_t       slot_sel;
    disp_types_pkg::glyph_addr_t mux_addr;

    rtc_apb_regs u_regs (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .time_now(time_now), .run_en(run_en), .presc_value(presc_value),
        .tset(tset), .cmd_load(cmd_load), .cmd_step(cmd_step)
    );

    rtc_time_counter u_counter (
        .clk(clk), .reset(reset),
        .run_en(run_en), .presc_value(presc_value), .tset(tset),
        .cmd_load(cmd_load), .cmd_step(cmd_step), .time_now(time_now)
    );

    rtc_glyph_mux u_mux (
        .slot_sel(slot_sel), .time_now(time_now), .glyph_addr(mux_addr)
    );

    rtc_char_scanner u_scanner (
        .clk(clk), .reset(reset),
        .glyph_addr_in(mux_addr), .slot_sel(slot_sel),
        .glyph_valid(glyph_valid), .glyph_ready(glyph_ready),
        .glyph_addr(glyph_addr), .glyph_slot(glyph_slot)
    );

endmodule

/* bench/rtc_display_sva.sv */
`timescale 1ns/100ps

module rtc_display_sva (
    input logic                        clk,
    input logic                        reset,
    input logic                        psel,
    input logic                        penable,
    input logic                        pready,
    input logic                        glyph_valid,
    input logic                        glyph_ready,
    input disp_types_pkg::glyph_addr_t glyph_addr,
    input disp_types_pkg::slot_t       glyph_slot
);

    // Zero wait states on the register bus
    assert property (@(posedge clk) disable iff (reset) psel && penable |-> pready)
        else $error("pready low in an APB access phase");

    // Stalled glyph held until taken
    assert property (@(posedge clk) disable iff (reset)
        glyph_valid && !glyph_ready |=> glyph_valid && $stable({glyph_addr, glyph_slot}))
        else $error("glyph item changed while the display engine stalled");

    // Nothing presented out of a reset cycle
    assert property (@(posedge clk) reset |=> !glyph_valid)
        else $error("glyph_valid high after a reset cycle");

endmodule

bind rtc_display_top rtc_display_sva u_sva (.*);

/* bench/tb_rtc_display.sv */
`timescale 1ns/100ps

`include "rtc_disp_defs.svh"

module tb_rtc_display;

    logic                        clk;
    logic                        reset;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic                        pready;
    logic                        pslverr;
    logic                        glyph_valid;
    logic                        glyph_ready;
    logic [7:0]                  paddr;
    logic [31:0]                 pwdata;
    logic [31:0]                 prdata;
    disp_types_pkg::glyph_addr_t glyph_addr;
    disp_types_pkg::slot_t       glyph_slot;
    // Watchdog counts of cycles run and records started
    int                          cycles;
    int                          rec_count;
    logic [31:0]                 lcg;

    rtc_display_top DUT (.*);

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Font ROM word of a digit glyph
    function automatic disp_types_pkg::glyph_addr_t digit_glyph_addr(input logic [3:0] d);
        return 11'd1024 + 11'd36 * d;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_apb_data(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        if (act !== exp)
            abort_run($sformatf("FAILED %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_time(input string name, input rtc_types_pkg::bcd_time_t exp,
                              input rtc_types_pkg::bcd_time_t act);
        if (act !== exp)
            abort_run($sformatf("FAILED %s expected %06h actual %06h", name, exp, act));
    endtask

    task automatic check_glyph(input string name,
                               input disp_types_pkg::glyph_addr_t exp_addr,
                               input disp_types_pkg::slot_t exp_slot,
                               input disp_types_pkg::glyph_addr_t act_addr,
                               input disp_types_pkg::slot_t act_slot);
        if (act_addr !== exp_addr || act_slot !== exp_slot)
            abort_run($sformatf("FAILED %s expected addr %0d slot %0d actual addr %0d slot %0d",
                                name, exp_addr, exp_slot, act_addr, act_slot));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus and display engine models
    ////////////////////////////////////////////////////////////////////////////

    // One setup and one access phase, response taken at the falling edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        step();
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1)
            abort_run("pready was not high in the APB access phase");
        rdata = prdata;
        err   = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Skip the frame in flight, then check each slot of the next one
    task automatic collect_frame(input string name, input rtc_types_pkg::bcd_time_t t);
        disp_types_pkg::glyph_addr_t exp_addr [8];
        int                          n;
        // Both colons sit at glyph code 10
        exp_addr = '{digit_glyph_addr(t.hour_10), digit_glyph_addr(t.hour_1), 11'd1384,
                     digit_glyph_addr(t.minute_10), digit_glyph_addr(t.minute_1), 11'd1384,
                     digit_glyph_addr(t.second_10), digit_glyph_addr(t.second_1)};
        n = 0;
        do
        begin
            @(negedge clk);
        end
        while (!(glyph_valid && glyph_ready && glyph_slot == 3'd7));
        while (n < 8)
        begin
            @(negedge clk);
            // Transfer lands on the next rising edge
            if (glyph_valid && glyph_ready)
            begin
                check_glyph(name, exp_addr[n], disp_types_pkg::slot_t'(n),
                            glyph_addr, glyph_slot);
                n++;
            end
        end
        step();
    endtask

    // Random ready plus the cycle limit
    initial
    begin
        glyph_ready = 1'b0;
        lcg         = 32'h0aec_9f70;
        cycles      = 0;
        forever
        begin
            step();
            lcg         = lcg_next(lcg);
            // Upper LCG bits are the useful ones
            glyph_ready = lcg[23];
            cycles++;
            // 256 cycles per record plus reset slack
            if (cycles > rec_count * 256 + 64)
                abort_run("Timeout, the run did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stim file player
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int              fd;
        string           line;
        string           name;
        logic [7:0]      kind;
        logic [8*16-1:0] name_raw;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     rdata;
        logic            err;
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        rec_count = 0;
        repeat (8) step();
        reset = 1'b0;
        fd = $fopen("bench/rtc_stim.txt", "r");
        if (fd == 0)
            abort_run("Could not open bench/rtc_stim.txt");
        while ($fgets(line, fd) != 0)
        begin
            // Comment and blank lines
            if ($sscanf(line, "%c %s %h %h %h", kind, name_raw, a, b, c) != 5 || kind == "#")
                continue;
            name = $sformatf("%0s", name_raw);
            rec_count++;
            case (kind)
                "W":
                begin
                    apb_xfer(1'b1, a[7:0], b, rdata, err);
                    check_apb_data(name, c, {31'd0, err});
                end
                "R":
                begin
                    apb_xfer(1'b0, a[7:0], 32'd0, rdata, err);
                    // Current time compared as BCD
                    if (a[7:0] == `RTC_OFF_TNOW)
                        check_time(name, b[23:0], rdata[23:0]);
                    else
                        check_apb_data(name, b, rdata);
                    check_apb_data(name, c, {31'd0, err});
                end
                "G": collect_frame(name, a[23:0]);
                "P": repeat (a) step();
                default: abort_run($sformatf("Unknown record kind %c in the stim file", kind));
            endcase
        end
        $fclose(fd);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* bench/rtc_stim.txt */
# kind name a b c, all numbers hex
# W addr wdata exp_pslverr | R addr exp_rdata exp_pslverr | G exp_time 0 0 | P cycles 0 0
W load_read 08 00123456 0
W load_read 04 00000001 0
R load_read 0c 00123456 0
R load_read 08 00123456 0
G glyph_frame 123456 0 0
W wrap_day 08 00235959 0
W wrap_day 04 00000001 0
W wrap_day 04 00000002 0
R wrap_day 0c 00000000 0
W wrap_hour 08 00095959 0
W wrap_hour 04 00000001 0
W wrap_hour 04 00000002 0
R wrap_hour 0c 00100000 0
W run_time 10 00000009 0
W run_time 08 00000058 0
W run_time 04 00000001 0
W run_time 04 00000003 0
P run_time 0a 0 0
R run_time 0c 00000059 0
P run_time 0a 0 0
R run_time 0c 00000100 0
W stop_hold 04 00000004 0
P stop_hold 28 0 0
R stop_hold 0c 00000100 0
W bad_addr 14 ffffffff 1
R bad_addr 14 00000000 1
R bad_addr 10 00000009 0

/* flist.f */
+incdir+include
hw/rtc_types_pkg.sv
hw/disp_types_pkg.sv
hw/rtc_apb_regs.sv
hw/rtc_time_counter.sv
hw/rtc_glyph_mux.sv
hw/rtc_char_scanner.sv
hw/rtc_display_top.sv
bench/rtc_display_sva.sv
bench/tb_rtc_display.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary -Wno-fatal -f flist.f --top-module tb_rtc_display -o sim_rtc \
    || { echo "Build failed"; exit 1; }
./obj_dir/sim_rtc > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "Run failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Run passed"
